// ==== source/bus_macros.svh ====
`ifndef BUS_MACROS_SVH
`define BUS_MACROS_SVH

// bus widths
`define ADDR_W 32
`define DATA_W 32
`define STRB_W (`DATA_W / 8)

// on-chip sram, only the word index bits are decoded
`define SRAM_WORDS 256
`define SRAM_BASE 32'h8000_0000

// machine timer words
`define MTIME_LO 32'h0200_0048
`define MTIME_HI 32'h0200_004c

// axi response codes
`define RESP_OKAY 2'b00

`endif

// ==== source/bus_pkg.sv ====
`default_nettype none

`include "bus_macros.svh"

package bus_pkg;

  ////////////////////////////////////////////////////////////
  // read channels
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [`ADDR_W-1:0] araddr;
    logic [7:0]         arlen;   // beats minus one
    logic [2:0]         arsize;
  } read_req_t;

  typedef struct packed {
    logic [`DATA_W-1:0] rdata;
    logic [1:0]         rresp;
    logic               rlast;
  } read_resp_t;

  ////////////////////////////////////////////////////////////
  // write channels
  ////////////////////////////////////////////////////////////

  // address and data go as one single-beat write
  typedef struct packed {
    logic [`ADDR_W-1:0] awaddr;
    logic [2:0]         awsize;
    logic [`DATA_W-1:0] wdata;
    logic [`STRB_W-1:0] wstrb;
  } write_req_t;

  typedef struct packed {
    logic [1:0] bresp;
  } write_resp_t;

  // bus owner
  typedef enum logic [1:0] {
    GRANT_IDLE  = 2'd0,
    GRANT_FETCH = 2'd1,
    GRANT_LS    = 2'd2
  } grant_t;

endpackage

`default_nettype wire

// ==== source/reg_slice.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_slice #(
  parameter type payload_t = logic
) (
  input  logic     clock,
  input  logic     reset,
  input  payload_t in_data,
  input  logic     in_valid,
  output logic     in_ready,
  output payload_t out_data,
  output logic     out_valid,
  input  logic     out_ready
);

  payload_t data_q;
  logic     full_q;

  // refill while the held item drains
  assign in_ready  = !full_q || out_ready;
  assign out_valid = full_q;
  assign out_data  = data_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      full_q <= 1'b0;
    end else if (in_valid && in_ready) begin
      full_q <= 1'b1;
    end else if (out_ready) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (in_valid && in_ready) data_q <= in_data;
  end

endmodule

`default_nettype wire

// ==== source/clint_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bus_macros.svh"

module clint_timer
  import bus_pkg::*;
(
  input  logic       clock,
  input  logic       reset,

  input  read_req_t  rd_req,
  input  logic       rd_req_valid,
  output logic       rd_req_ready,

  output read_resp_t rd_resp,
  output logic       rd_resp_valid,
  input  logic       rd_resp_ready
);

  logic [63:0]        mtime_q;
  logic [`DATA_W-1:0] hi_snap_q; // high word seen at the last low read
  logic [`DATA_W-1:0] rdata_q;
  logic               valid_q;
  logic               accept;
  logic               read_hi;

  assign accept  = rd_req_valid && rd_req_ready;
  assign read_hi = (rd_req.araddr == `MTIME_HI);

  assign rd_req_ready  = !valid_q; // one read in flight
  assign rd_resp_valid = valid_q;
  assign rd_resp       = '{rdata: rdata_q, rresp: `RESP_OKAY, rlast: 1'b1};

  ////////////////////////////////////////////////////////////
  // counter and response control
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      mtime_q   <= '0;
      hi_snap_q <= '0;
      valid_q   <= 1'b0;
    end else begin
      mtime_q <= mtime_q + 64'd1;
      if (accept) begin
        valid_q <= 1'b1;
        if (!read_hi) hi_snap_q <= mtime_q[63:32];
      end else if (rd_resp_ready) begin
        valid_q <= 1'b0;
      end
    end
  end

  // high read returns the snapshot so a lo/hi pair is consistent
  always_ff @(posedge clock) begin
    if (accept) begin
      rdata_q <= read_hi ? hi_snap_q : mtime_q[31:0];
    end
  end

endmodule

`default_nettype wire

// ==== source/sram_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bus_macros.svh"

module sram_slave
  import bus_pkg::*;
(
  input  logic        clock,
  input  logic        reset,

  input  read_req_t   rd_req,
  input  logic        rd_req_valid,
  output logic        rd_req_ready,

  output read_resp_t  rd_resp,
  output logic        rd_resp_valid,
  input  logic        rd_resp_ready,

  input  write_req_t  wr_req,
  input  logic        wr_req_valid,
  output logic        wr_req_ready,

  output write_resp_t wr_resp,
  output logic        wr_resp_valid,
  input  logic        wr_resp_ready
);

  localparam int IDX_W = $clog2(`SRAM_WORDS);

  logic [`DATA_W-1:0] mem [`SRAM_WORDS];

  logic               busy_q;   // burst in progress
  logic [7:0]         beat_q;
  logic [7:0]         len_q;
  logic [IDX_W-1:0]   idx_q;
  logic [`DATA_W-1:0] rdata_q;
  logic               wr_done_q;

  logic               rd_accept;
  logic               rd_next;
  logic               rd_final;
  logic               wr_accept;
  logic [IDX_W-1:0]   rd_idx;
  logic [IDX_W-1:0]   wr_idx;

  assign rd_idx    = rd_req.araddr[IDX_W+1:2];
  assign wr_idx    = wr_req.awaddr[IDX_W+1:2];
  assign rd_accept = rd_req_valid && rd_req_ready;
  assign rd_final  = (beat_q == len_q);
  assign rd_next   = rd_resp_valid && rd_resp_ready && !rd_final;
  assign wr_accept = wr_req_valid && wr_req_ready;

  assign rd_req_ready  = !busy_q;
  assign rd_resp_valid = busy_q;
  assign rd_resp       = '{rdata: rdata_q, rresp: `RESP_OKAY, rlast: rd_final};

  assign wr_req_ready  = !wr_done_q;
  assign wr_resp_valid = wr_done_q;
  assign wr_resp       = '{bresp: `RESP_OKAY};

  ////////////////////////////////////////////////////////////
  // read burst
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      busy_q <= 1'b0;
      beat_q <= '0;
    end else if (rd_accept) begin
      busy_q <= 1'b1;
      beat_q <= '0;
    end else if (rd_resp_valid && rd_resp_ready) begin
      if (rd_final) busy_q <= 1'b0;
      else beat_q <= beat_q + 8'd1;
    end
  end

  // next word is fetched as the current beat leaves
  always_ff @(posedge clock) begin
    if (rd_accept) begin
      len_q   <= rd_req.arlen;
      idx_q   <= rd_idx;
      rdata_q <= mem[rd_idx];
    end else if (rd_next) begin
      idx_q   <= idx_q + 1'b1;
      rdata_q <= mem[idx_q + 1'b1];
    end
  end

  ////////////////////////////////////////////////////////////
  // strobed write
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (wr_accept) begin
      for (int b = 0; b < `STRB_W; b++) begin
        if (wr_req.wstrb[b]) mem[wr_idx][8*b +: 8] <= wr_req.wdata[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_done_q <= 1'b0;
    end else if (wr_accept) begin
      wr_done_q <= 1'b1;
    end else if (wr_resp_ready) begin
      wr_done_q <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== source/bus_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bus_macros.svh"

module bus_arbiter
  import bus_pkg::*;
(
  input  logic        clock,
  input  logic        reset,

  input  logic        fetch_busy,
  input  logic        ls_busy,

  // fetch master
  input  read_req_t   fetch_req,
  input  logic        fetch_req_valid,
  output logic        fetch_req_ready,
  output read_resp_t  fetch_resp,
  output logic        fetch_resp_valid,
  input  logic        fetch_resp_ready,

  // load/store master
  input  read_req_t   ls_rd_req,
  input  logic        ls_rd_req_valid,
  output logic        ls_rd_req_ready,
  output read_resp_t  ls_rd_resp,
  output logic        ls_rd_resp_valid,
  input  logic        ls_rd_resp_ready,
  input  write_req_t  ls_wr_req,
  input  logic        ls_wr_req_valid,
  output logic        ls_wr_req_ready,
  output write_resp_t ls_wr_resp,
  output logic        ls_wr_resp_valid,
  input  logic        ls_wr_resp_ready,

  // sram side
  output read_req_t   mem_rd_req,
  output logic        mem_rd_req_valid,
  input  logic        mem_rd_req_ready,
  input  read_resp_t  mem_rd_resp,
  input  logic        mem_rd_resp_valid,
  output logic        mem_rd_resp_ready,
  output write_req_t  mem_wr_req,
  output logic        mem_wr_req_valid,
  input  logic        mem_wr_req_ready,
  input  write_resp_t mem_wr_resp,
  input  logic        mem_wr_resp_valid,
  output logic        mem_wr_resp_ready,

  // timer side
  output read_req_t   tmr_rd_req,
  output logic        tmr_rd_req_valid,
  input  logic        tmr_rd_req_ready,
  input  read_resp_t  tmr_rd_resp,
  input  logic        tmr_rd_resp_valid,
  output logic        tmr_rd_resp_ready
);

  grant_t grant_q;
  logic   tmr_hit_q;  // ls read targets the timer
  logic   ls_tmr_addr;
  logic   fetch_on;
  logic   ls_on;
  logic   ls_mem;
  logic   ls_tmr;

  assign ls_tmr_addr = (ls_rd_req.araddr == `MTIME_LO) || (ls_rd_req.araddr == `MTIME_HI);

  assign fetch_on = (grant_q == GRANT_FETCH);
  assign ls_on    = (grant_q == GRANT_LS);
  assign ls_mem   = ls_on && !tmr_hit_q;
  assign ls_tmr   = ls_on && tmr_hit_q;

  ////////////////////////////////////////////////////////////
  // grant fsm
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      grant_q   <= GRANT_IDLE;
      tmr_hit_q <= 1'b0;
    end else begin
      case (grant_q)
        GRANT_IDLE: begin
          if (ls_busy) begin  // ls wins a tie
            grant_q   <= GRANT_LS;
            tmr_hit_q <= ls_tmr_addr;
          end else if (fetch_busy) begin
            grant_q <= GRANT_FETCH;
          end
        end
        GRANT_FETCH: if (!fetch_busy) grant_q <= GRANT_IDLE;
        GRANT_LS:    if (!ls_busy) grant_q <= GRANT_IDLE;
        default:     grant_q <= GRANT_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // channel steering
  ////////////////////////////////////////////////////////////

  // read requests
  assign mem_rd_req       = fetch_on ? fetch_req : ls_rd_req;
  assign mem_rd_req_valid = (fetch_on && fetch_req_valid) || (ls_mem && ls_rd_req_valid);
  assign tmr_rd_req       = ls_rd_req;
  assign tmr_rd_req_valid = ls_tmr && ls_rd_req_valid;
  assign fetch_req_ready  = fetch_on && mem_rd_req_ready;
  assign ls_rd_req_ready  = ls_on && (tmr_hit_q ? tmr_rd_req_ready : mem_rd_req_ready);

  // read responses
  assign fetch_resp        = mem_rd_resp;
  assign fetch_resp_valid  = fetch_on && mem_rd_resp_valid;
  assign ls_rd_resp        = tmr_hit_q ? tmr_rd_resp : mem_rd_resp;
  assign ls_rd_resp_valid  = ls_on && (tmr_hit_q ? tmr_rd_resp_valid : mem_rd_resp_valid);
  assign mem_rd_resp_ready = (fetch_on && fetch_resp_ready) || (ls_mem && ls_rd_resp_ready);
  assign tmr_rd_resp_ready = ls_tmr && ls_rd_resp_ready;

  // writes only come from the ls port
  assign mem_wr_req        = ls_wr_req;
  assign mem_wr_req_valid  = ls_on && ls_wr_req_valid;
  assign ls_wr_req_ready   = ls_on && mem_wr_req_ready;
  assign ls_wr_resp        = mem_wr_resp;
  assign ls_wr_resp_valid  = ls_on && mem_wr_resp_valid;
  assign mem_wr_resp_ready = ls_on && ls_wr_resp_ready;

endmodule

`default_nettype wire

// ==== source/soc_bus_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_bus_top
  import bus_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  logic        fetch_busy,
  input  logic        ls_busy,
  input  read_req_t   fetch_req,
  input  logic        fetch_req_valid,
  output logic        fetch_req_ready,
  output read_resp_t  fetch_resp,
  output logic        fetch_resp_valid,
  input  logic        fetch_resp_ready,
  input  read_req_t   ls_rd_req,
  input  logic        ls_rd_req_valid,
  output logic        ls_rd_req_ready,
  output read_resp_t  ls_rd_resp,
  output logic        ls_rd_resp_valid,
  input  logic        ls_rd_resp_ready,
  input  write_req_t  ls_wr_req,
  input  logic        ls_wr_req_valid,
  output logic        ls_wr_req_ready,
  output write_resp_t ls_wr_resp,
  output logic        ls_wr_resp_valid,
  input  logic        ls_wr_resp_ready
);

  // arbiter to response slices
  read_resp_t  arb_fetch_resp;
  logic        arb_fetch_resp_valid, arb_fetch_resp_ready;
  write_resp_t arb_wr_resp;
  logic        arb_wr_resp_valid, arb_wr_resp_ready;

  // arbiter to slaves
  read_req_t   mem_rd_req, tmr_rd_req;
  read_resp_t  mem_rd_resp, tmr_rd_resp;
  write_req_t  mem_wr_req;
  write_resp_t mem_wr_resp;
  logic        mem_rd_req_valid, mem_rd_req_ready, mem_rd_resp_valid, mem_rd_resp_ready;
  logic        mem_wr_req_valid, mem_wr_req_ready, mem_wr_resp_valid, mem_wr_resp_ready;
  logic        tmr_rd_req_valid, tmr_rd_req_ready, tmr_rd_resp_valid, tmr_rd_resp_ready;

  bus_arbiter u_arbiter (
    .clock, .reset, .fetch_busy, .ls_busy,
    .fetch_req, .fetch_req_valid, .fetch_req_ready,
    .fetch_resp(arb_fetch_resp), .fetch_resp_valid(arb_fetch_resp_valid),
    .fetch_resp_ready(arb_fetch_resp_ready),
    .ls_rd_req, .ls_rd_req_valid, .ls_rd_req_ready,
    .ls_rd_resp, .ls_rd_resp_valid, .ls_rd_resp_ready,
    .ls_wr_req, .ls_wr_req_valid, .ls_wr_req_ready,
    .ls_wr_resp(arb_wr_resp), .ls_wr_resp_valid(arb_wr_resp_valid),
    .ls_wr_resp_ready(arb_wr_resp_ready),
    .mem_rd_req, .mem_rd_req_valid, .mem_rd_req_ready,
    .mem_rd_resp, .mem_rd_resp_valid, .mem_rd_resp_ready,
    .mem_wr_req, .mem_wr_req_valid, .mem_wr_req_ready,
    .mem_wr_resp, .mem_wr_resp_valid, .mem_wr_resp_ready,
    .tmr_rd_req, .tmr_rd_req_valid, .tmr_rd_req_ready,
    .tmr_rd_resp, .tmr_rd_resp_valid, .tmr_rd_resp_ready
  );

  sram_slave u_sram (
    .clock, .reset,
    .rd_req(mem_rd_req), .rd_req_valid(mem_rd_req_valid), .rd_req_ready(mem_rd_req_ready),
    .rd_resp(mem_rd_resp), .rd_resp_valid(mem_rd_resp_valid),
    .rd_resp_ready(mem_rd_resp_ready),
    .wr_req(mem_wr_req), .wr_req_valid(mem_wr_req_valid), .wr_req_ready(mem_wr_req_ready),
    .wr_resp(mem_wr_resp), .wr_resp_valid(mem_wr_resp_valid),
    .wr_resp_ready(mem_wr_resp_ready)
  );

  clint_timer u_timer (
    .clock, .reset,
    .rd_req(tmr_rd_req), .rd_req_valid(tmr_rd_req_valid), .rd_req_ready(tmr_rd_req_ready),
    .rd_resp(tmr_rd_resp), .rd_resp_valid(tmr_rd_resp_valid),
    .rd_resp_ready(tmr_rd_resp_ready)
  );

  reg_slice #(.payload_t(read_resp_t)) u_fetch_slice (
    .clock, .reset,
    .in_data(arb_fetch_resp), .in_valid(arb_fetch_resp_valid),
    .in_ready(arb_fetch_resp_ready),
    .out_data(fetch_resp), .out_valid(fetch_resp_valid), .out_ready(fetch_resp_ready)
  );

  reg_slice #(.payload_t(write_resp_t)) u_wr_slice (
    .clock, .reset,
    .in_data(arb_wr_resp), .in_valid(arb_wr_resp_valid), .in_ready(arb_wr_resp_ready),
    .out_data(ls_wr_resp), .out_valid(ls_wr_resp_valid), .out_ready(ls_wr_resp_ready)
  );

endmodule

`default_nettype wire

// ==== verification/bus_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_assertions
  import bus_pkg::*;
(
  input logic       clock,
  input logic       reset,
  input grant_t     grant_q,
  input logic       tmr_hit_q,
  input read_resp_t mem_rd_resp,
  input logic       mem_rd_resp_valid,
  input logic       mem_rd_resp_ready,
  input logic       mem_wr_resp_valid,
  input read_resp_t tmr_rd_resp,
  input logic       tmr_rd_resp_valid,
  input logic       tmr_rd_resp_ready
);

  int fail_count = 0;

  ////////////////////////////////////////////////////////////
  // grant rules
  ////////////////////////////////////////////////////////////

  // one owner at a time, the bus always passes through idle
  grant_via_idle: assert property (@(posedge clock) disable iff (reset)
    grant_q != GRANT_IDLE |=> (grant_q == $past(grant_q)) || (grant_q == GRANT_IDLE))
    else begin
      fail_count++;
      $error("grant moved from one master to the other without an idle cycle");
    end

  mem_rd_owned: assert property (@(posedge clock) disable iff (reset)
    mem_rd_resp_valid |-> (grant_q == GRANT_FETCH) || (grant_q == GRANT_LS && !tmr_hit_q))
    else begin
      fail_count++;
      $error("sram read response valid while no master is granted to take it");
    end

  mem_wr_owned: assert property (@(posedge clock) disable iff (reset)
    mem_wr_resp_valid |-> grant_q == GRANT_LS)
    else begin
      fail_count++;
      $error("sram write response valid while load/store port is not granted");
    end

  tmr_owned: assert property (@(posedge clock) disable iff (reset)
    tmr_rd_resp_valid |-> (grant_q == GRANT_LS) && tmr_hit_q)
    else begin
      fail_count++;
      $error("timer read response valid while no timer read is granted");
    end

  ////////////////////////////////////////////////////////////
  // valid holds until ready
  ////////////////////////////////////////////////////////////

  mem_resp_hold: assert property (@(posedge clock) disable iff (reset)
    mem_rd_resp_valid && !mem_rd_resp_ready |=> mem_rd_resp_valid && $stable(mem_rd_resp))
    else begin
      fail_count++;
      $error("sram read response dropped or changed before ready");
    end

  tmr_resp_hold: assert property (@(posedge clock) disable iff (reset)
    tmr_rd_resp_valid && !tmr_rd_resp_ready |=> tmr_rd_resp_valid && $stable(tmr_rd_resp))
    else begin
      fail_count++;
      $error("timer read response dropped or changed before ready");
    end

endmodule

`default_nettype wire

// ==== verification/bus_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bus_macros.svh"

module bus_checker
  import bus_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  logic        order_check,   // contention round in progress
  input  read_req_t   fetch_req,
  input  logic        fetch_req_valid,
  input  logic        fetch_req_ready,
  input  read_resp_t  fetch_resp,
  input  logic        fetch_resp_valid,
  input  logic        fetch_resp_ready,
  input  read_req_t   ls_rd_req,
  input  logic        ls_rd_req_valid,
  input  logic        ls_rd_req_ready,
  input  read_resp_t  ls_rd_resp,
  input  logic        ls_rd_resp_valid,
  input  logic        ls_rd_resp_ready,
  input  write_req_t  ls_wr_req,
  input  logic        ls_wr_req_valid,
  input  logic        ls_wr_req_ready,
  input  write_resp_t ls_wr_resp,
  input  logic        ls_wr_resp_valid,
  input  logic        ls_wr_resp_ready,
  output int          check_count,
  output int          error_count
);

  logic [`DATA_W-1:0] ref_mem [`SRAM_WORDS];
  string              test_name;
  int                 first_check;
  int                 first_error;
  logic [63:0]        cycle_q;      // cycles since reset, same rule as mtime
  int                 fetch_base;
  int                 fetch_len;
  int                 fetch_beat;
  logic [31:0]        ls_expect;
  logic               ls_timer;
  logic               ls_hi;
  logic [31:0]        snap_hi;
  logic [31:0]        lo_seen;
  logic [63:0]        last_time;
  logic               have_time;
  logic               ls_done;

  initial begin
    check_count = 0;
    error_count = 0;
    test_name   = "none";
  end

  function automatic int word_index(input logic [31:0] addr);
    return int'(((addr - `SRAM_BASE) >> 2) % `SRAM_WORDS);
  endfunction

  // expected sram word after a strobed write
  function automatic logic [31:0] merge_word(input logic [31:0] old, input logic [31:0] data,
                                             input logic [3:0] strb);
    logic [31:0] w;
    w = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) w[8*b +: 8] = data[8*b +: 8];
    end
    return w;
  endfunction

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("Error: %s %s expected %h actual %h", test_name, what, expected, actual);
    end
  endtask

  task automatic check_true(input logic cond, input string msg);
    check_count++;
    if (!cond) begin
      error_count++;
      $display("%s: %s", test_name, msg);
    end
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    first_check = check_count;
    first_error = error_count;
  endtask

  task automatic finish_test();
    $display("test %s: %0d checks, %0d errors", test_name,
             check_count - first_check, error_count - first_error);
  endtask

  ////////////////////////////////////////////////////////////
  // transfer monitor
  ////////////////////////////////////////////////////////////

  always @(posedge clock) begin
    if (reset) begin
      cycle_q   <= '0;
      have_time = 1'b0;
      ls_done   = 1'b0;
    end else begin
      cycle_q <= cycle_q + 64'd1;
      if (!order_check) ls_done = 1'b0;

      if (ls_wr_req_valid && ls_wr_req_ready) begin
        ref_mem[word_index(ls_wr_req.awaddr)] =
          merge_word(ref_mem[word_index(ls_wr_req.awaddr)], ls_wr_req.wdata, ls_wr_req.wstrb);
      end
      if (ls_wr_resp_valid && ls_wr_resp_ready) begin
        check_value("bresp", 32'(`RESP_OKAY), 32'(ls_wr_resp.bresp));
        if (order_check) ls_done = 1'b1;
      end

      // timer words are predicted from the cycle count at acceptance
      if (ls_rd_req_valid && ls_rd_req_ready) begin
        ls_timer = (ls_rd_req.araddr == `MTIME_LO) || (ls_rd_req.araddr == `MTIME_HI);
        ls_hi    = (ls_rd_req.araddr == `MTIME_HI);
        if (!ls_timer) begin
          ls_expect = ref_mem[word_index(ls_rd_req.araddr)];
        end else if (!ls_hi) begin
          ls_expect = cycle_q[31:0];
          snap_hi   = cycle_q[63:32];
        end else begin
          ls_expect = snap_hi;
        end
      end
      if (ls_rd_resp_valid && ls_rd_resp_ready) begin
        check_value(ls_timer ? "mtime" : "load", ls_expect, ls_rd_resp.rdata);
        check_value("load resp", 32'(`RESP_OKAY), 32'(ls_rd_resp.rresp));
        check_value("load last", 32'd1, 32'(ls_rd_resp.rlast));
        if (ls_timer && !ls_hi) lo_seen = ls_rd_resp.rdata;
        if (ls_timer && ls_hi) begin
          check_true(!have_time || ({ls_rd_resp.rdata, lo_seen} > last_time),
                     "timer value did not increase between read pairs");
          last_time = {ls_rd_resp.rdata, lo_seen};
          have_time = 1'b1;
        end
      end

      if (fetch_req_valid && fetch_req_ready) begin
        fetch_base = word_index(fetch_req.araddr);
        fetch_len  = int'(fetch_req.arlen);
        fetch_beat = 0;
      end
      if (fetch_resp_valid && fetch_resp_ready) begin
        check_value("burst data", ref_mem[(fetch_base + fetch_beat) % `SRAM_WORDS],
                    fetch_resp.rdata);
        check_value("burst resp", 32'(`RESP_OKAY), 32'(fetch_resp.rresp));
        check_value("burst last", 32'(fetch_beat == fetch_len), 32'(fetch_resp.rlast));
        if (fetch_resp.rlast && order_check) begin
          check_true(ls_done, "fetch burst finished before the load/store write");
        end
        fetch_beat++;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verification/tb_soc_bus.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bus_macros.svh"

module tb_soc_bus
  import bus_pkg::*;
();

  localparam int PERIOD     = 100;
  localparam int RST_CYCLES = 16;
  localparam int N_FILL     = 32;   // words in the test window
  localparam int N_WRITES   = 16;
  localparam int N_BURSTS   = 12;
  localparam int N_ROUNDS   = 4;
  localparam int N_TXNS     = N_FILL + 2 * N_WRITES + 2 * N_BURSTS + 2 * N_ROUNDS + 8;

  logic        clock;
  logic        reset;
  logic        fetch_busy;
  logic        ls_busy;
  read_req_t   fetch_req;
  logic        fetch_req_valid;
  logic        fetch_req_ready;
  read_resp_t  fetch_resp;
  logic        fetch_resp_valid;
  logic        fetch_resp_ready;
  read_req_t   ls_rd_req;
  logic        ls_rd_req_valid;
  logic        ls_rd_req_ready;
  read_resp_t  ls_rd_resp;
  logic        ls_rd_resp_valid;
  logic        ls_rd_resp_ready;
  write_req_t  ls_wr_req;
  logic        ls_wr_req_valid;
  logic        ls_wr_req_ready;
  write_resp_t ls_wr_resp;
  logic        ls_wr_resp_valid;
  logic        ls_wr_resp_ready;

  logic        order_check;
  int          check_count;
  int          error_count;
  int          tests_run;
  int          assert_fails;
  logic [15:0] lfsr_q;

  soc_bus_top DUT (.*);

  bus_checker u_checker (.*);

  bind bus_arbiter bus_assertions u_arbiter_checks (.*);

  initial begin
    clock = 1'b0;
    forever #(PERIOD / 2) clock = ~clock;
  end

  initial begin
    repeat (RST_CYCLES + 40 * N_TXNS) @(posedge clock);
    $display("watchdog: run did not finish within %0d transactions of time", N_TXNS);
    $display("Testbench failed");
    $finish;
  end

  // galois lfsr, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v      = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hb400) : (lfsr_q >> 1);
    end
    return v;
  endfunction

  function automatic logic [31:0] word_addr(input int idx);
    return `SRAM_BASE + 32'(idx << 2);
  endfunction

  ////////////////////////////////////////////////////////////
  // master tasks
  ////////////////////////////////////////////////////////////

  task automatic ls_write(input logic [31:0] addr, input logic [31:0] data,
                          input logic [3:0] strb);
    ls_busy          <= 1'b1;
    ls_rd_req.araddr <= addr;  // decoded at grant
    ls_wr_req        <= '{awaddr: addr, awsize: 3'd2, wdata: data, wstrb: strb};
    ls_wr_req_valid  <= 1'b1;
    do @(posedge clock); while (!(ls_wr_req_valid && ls_wr_req_ready));
    ls_wr_req_valid  <= 1'b0;
    ls_wr_resp_ready <= 1'b1;
    do @(posedge clock); while (!(ls_wr_resp_valid && ls_wr_resp_ready));
    ls_wr_resp_ready <= 1'b0;
    ls_busy          <= 1'b0;
    @(posedge clock);  // let the arbiter see busy low
  endtask

  task automatic ls_read(input logic [31:0] addr);
    ls_busy          <= 1'b1;
    ls_rd_req        <= '{araddr: addr, arlen: 8'd0, arsize: 3'd2};
    ls_rd_req_valid  <= 1'b1;
    do @(posedge clock); while (!(ls_rd_req_valid && ls_rd_req_ready));
    ls_rd_req_valid  <= 1'b0;
    repeat (int'(rand_bits(2))) @(posedge clock);  // response waits for ready
    ls_rd_resp_ready <= 1'b1;
    do @(posedge clock); while (!(ls_rd_resp_valid && ls_rd_resp_ready));
    ls_rd_resp_ready <= 1'b0;
    ls_busy          <= 1'b0;
    @(posedge clock);
  endtask

  task automatic fetch_burst(input logic [31:0] addr, input logic [7:0] len, input logic bp);
    int beats;
    beats = 0;
    fetch_busy      <= 1'b1;
    fetch_req       <= '{araddr: addr, arlen: len, arsize: 3'd2};
    fetch_req_valid <= 1'b1;
    do @(posedge clock); while (!(fetch_req_valid && fetch_req_ready));
    fetch_req_valid <= 1'b0;
    while (beats <= int'(len)) begin
      fetch_resp_ready <= bp ? (rand_bits(1) != 0) : 1'b1;  // random gaps
      @(posedge clock);
      if (fetch_resp_valid && fetch_resp_ready) beats++;
    end
    fetch_resp_ready <= 1'b0;
    fetch_busy       <= 1'b0;
    @(posedge clock);
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int          idx;
    logic [31:0] data;
    logic [3:0]  strb;

    lfsr_q           = 16'd3107;
    reset            = 1'b1;
    fetch_busy       = 1'b0;
    ls_busy          = 1'b0;
    fetch_req        = '0;
    fetch_req_valid  = 1'b0;
    fetch_resp_ready = 1'b0;
    ls_rd_req        = '0;
    ls_rd_req_valid  = 1'b0;
    ls_rd_resp_ready = 1'b0;
    ls_wr_req        = '0;
    ls_wr_req_valid  = 1'b0;
    ls_wr_resp_ready = 1'b0;
    order_check      = 1'b0;
    tests_run        = 0;
    repeat (RST_CYCLES) @(posedge clock);
    reset <= 1'b0;
    @(posedge clock);

    u_checker.start_test("write_readback");
    for (int i = 0; i < N_FILL; i++) ls_write(word_addr(i), rand_bits(32), 4'hf);
    for (int i = 0; i < N_WRITES; i++) begin
      idx = int'(rand_bits(5));
      ls_write(word_addr(idx), rand_bits(32), 4'(rand_bits(4)));
      ls_read(word_addr(idx));
    end
    u_checker.finish_test();
    tests_run++;

    u_checker.start_test("fetch_bursts");
    for (int i = 0; i < N_BURSTS; i++) begin
      fetch_burst(word_addr(int'(rand_bits(5) % 28)), 8'(rand_bits(2)), 1'b0);
    end
    u_checker.finish_test();
    tests_run++;

    // both masters ask on the same cycle
    u_checker.start_test("contention");
    for (int r = 0; r < N_ROUNDS; r++) begin
      idx  = int'(rand_bits(5) % 28);
      data = rand_bits(32);
      strb = 4'(rand_bits(4));
      order_check <= 1'b1;
      fork
        ls_write(word_addr(idx), data, strb);
        fetch_burst(word_addr(idx), 8'd3, 1'b0);
      join
      order_check <= 1'b0;
      @(posedge clock);
    end
    u_checker.finish_test();
    tests_run++;

    u_checker.start_test("back_pressure");
    for (int i = 0; i < N_BURSTS; i++) begin
      fetch_burst(word_addr(int'(rand_bits(5) % 28)), 8'(rand_bits(2)), 1'b1);
    end
    u_checker.finish_test();
    tests_run++;

    u_checker.start_test("timer");
    for (int i = 0; i < 2; i++) begin
      ls_read(`MTIME_LO);
      ls_read(`MTIME_HI);
      repeat (5) @(posedge clock);
    end
    for (int i = 0; i < 4; i++) ls_read(word_addr(int'(rand_bits(5))));
    u_checker.finish_test();
    tests_run++;

    assert_fails = DUT.u_arbiter.u_arbiter_checks.fail_count;
    $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
             tests_run, check_count, error_count, assert_fails);
    if (error_count == 0 && assert_fails == 0 && check_count > 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+source
source/bus_pkg.sv
source/reg_slice.sv
source/clint_timer.sv
source/sram_slave.sv
source/bus_arbiter.sv
source/soc_bus_top.sv
verification/bus_assertions.sv
verification/bus_checker.sv
verification/tb_soc_bus.sv
